//--- include/fht_defines.svh
`ifndef FHT_DEFINES_SVH
`define FHT_DEFINES_SVH

// Transform length, points per row and per column
`define FHT_PTS 8

// Input sample width
`define SAMPLE_W 8

// Width of the words between stages and at the output
`define WORD_W 16

// Coefficients in Q1.14
`define COEF_FRAC 14

// 1.0 in Q1.14
`define COEF_ONE 16384

// sqrt(2) in Q1.14, rounded to nearest
`define COEF_SQRT2 23170

`endif

//--- design/fht_pkg.sv
`include "fht_defines.svh"

package fht_pkg;

  // Signed input sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // Transform word, stage to stage and at the output
  typedef logic signed [`WORD_W-1:0] word_t;

  typedef logic signed [15:0] coef_t;  // Q1.14, range about -2..+2

  // cas(2*pi*p/8) = cos + sin, indexed by phase p = n*k mod 8
  // Only 0, +-1 and +-sqrt2 occur for an 8-point kernel
  function automatic coef_t cas_coef(input logic [2:0] phase);
    coef_t c;
    case (phase)
      3'd0: c = coef_t'(`COEF_ONE);     // cos 0 + sin 0
      3'd1: c = coef_t'(`COEF_SQRT2);   // 45 deg
      3'd2: c = coef_t'(`COEF_ONE);     // 90 deg
      3'd4: c = -coef_t'(`COEF_ONE);    // 180 deg
      3'd5: c = -coef_t'(`COEF_SQRT2);  // 225 deg
      3'd6: c = -coef_t'(`COEF_ONE);    // 270 deg
      default: c = '0;                  // 135 and 315 deg cancel
    endcase
    return c;
  endfunction

endpackage

//--- design/dpsram_128x16.sv
`timescale 1ns/1ps

module dpsram_128x16
  import fht_pkg::*;
(
  input  logic       sclk,
  input  logic       wr_en,
  input  logic [6:0] wr_addr,
  input  word_t      wr_data,
  input  logic       rd_en,
  input  logic [6:0] rd_addr,
  output word_t      rd_data
);

  word_t mem [128];  // Two 64-word halves

  always_ff @(posedge sclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;  // Write port
    end
  end

  // Registered read, data valid the cycle after rd_en
  always_ff @(posedge sclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Same-address read and write in one cycle has no defined result
  a_no_rw_collision: assert property (
    @(posedge sclk) (wr_en && rd_en) |-> (wr_addr != rd_addr)
  );

endmodule

//--- design/fht_1d_8pt.sv
`timescale 1ns/1ps
`include "fht_defines.svh"

module fht_1d_8pt
  import fht_pkg::*;
#(
  parameter int IN_W = 8  // 8 for the row pass, 16 for the column pass
) (
  input  logic                   sclk,
  input  logic                   rstn,
  input  logic                   in_valid,
  input  logic signed [IN_W-1:0] in_data,
  output logic                   out_valid,
  output word_t                  out_data
);

  localparam int ACC_W = 2 * `WORD_W + 3;  // 32-bit products, 8 terms

  logic [2:0] fill_cnt;  // Position in the group being collected
  logic       load;      // Eighth word of a group arrives
  logic       busy;      // Emit bank is being transformed
  logic [2:0] freq_cnt;  // Output frequency k

  word_t in_word;                   // Input sign-extended to a word
  word_t col_bank  [`FHT_PTS-1];    // Words 0..6, word 7 goes straight through
  word_t emit_bank [`FHT_PTS];

  logic [2:0]                  phase [`FHT_PTS];
  logic signed [2*`WORD_W-1:0] prod  [`FHT_PTS];
  logic signed [ACC_W-1:0]     sum;
  logic signed [ACC_W-1:0]     sum_shr;

  assign in_word = word_t'(in_data);
  assign load    = in_valid && (fill_cnt == 3'(`FHT_PTS - 1));

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      fill_cnt <= '0;
    end else if (in_valid) begin
      fill_cnt <= fill_cnt + 3'd1;  // Wraps after 8
    end
  end

  // Collect bank, first seven words of a group
  always_ff @(posedge sclk) begin
    if (in_valid && !load) begin
      col_bank[fill_cnt] <= in_word;
    end
  end

  // Whole group moves to the emit bank on the eighth word
  always_ff @(posedge sclk) begin
    if (load) begin
      for (int n = 0; n < `FHT_PTS - 1; n++) begin
        emit_bank[n] <= col_bank[n];
      end
      emit_bank[`FHT_PTS-1] <= in_word;
    end
  end

  // Frequency sequencer, k = 0..7 then idle
  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      busy     <= 1'b0;
      freq_cnt <= '0;
    end else if (load) begin
      busy     <= 1'b1;  // Restart, may land on the last k of the previous group
      freq_cnt <= '0;
    end else if (busy) begin
      freq_cnt <= freq_cnt + 3'd1;
      if (freq_cnt == 3'(`FHT_PTS - 1)) begin
        busy <= 1'b0;
      end
    end
  end

  // One product per point for the current k
  for (genvar n = 0; n < `FHT_PTS; n++) begin : g_prod
    assign phase[n] = freq_cnt * 3'(n);  // n*k mod 8
    assign prod[n]  = emit_bank[n] * cas_coef(phase[n]);
  end

  always_comb begin
    sum = '0;
    for (int n = 0; n < `FHT_PTS; n++) begin
      sum = sum + prod[n];  // Full precision
    end
  end

  assign sum_shr = sum >>> `COEF_FRAC;  // Arithmetic, no rounding

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= busy;
    end
  end

  always_ff @(posedge sclk) begin
    if (busy) begin
      out_data <= sum_shr[`WORD_W-1:0];  // Truncate to 16 bits
    end
  end

  // A new group may only start on the final frequency of the running one
  a_no_emit_overlap: assert property (
    @(posedge sclk) disable iff (!rstn)
    (load && busy) |-> (freq_cnt == 3'(`FHT_PTS - 1))
  );

  // Eight output cycles follow every group
  a_eight_outputs: assert property (
    @(posedge sclk) disable iff (!rstn)
    load |-> ##2 out_valid [*8]
  );

  // and no ninth unless another group arrived
  a_burst_ends: assert property (
    @(posedge sclk) disable iff (!rstn)
    load ##1 (!load) [*8] |-> ##2 !out_valid
  );

endmodule

//--- design/mtx_trps_8x8_dpsram.sv
`timescale 1ns/1ps

module mtx_trps_8x8_dpsram
  import fht_pkg::*;
(
  input  logic  sclk,
  input  logic  rstn,
  input  logic  inp_valid,
  input  word_t inp_data,
  output logic  mem_valid,
  output word_t mem_data
);

  logic [6:0] wr_cnt;     // Write address, bit 6 selects the half
  logic       half_1d;    // wr_cnt[6] one cycle late
  logic       half_done;  // A half has just filled
  logic [6:0] rd_cnt;     // Read index, bit 6 follows the write halves
  logic       rd_active;  // Read burst running, also the RAM read enable
  logic       rd_last;    // Last word of a burst
  logic [6:0] rd_addr;
  word_t      rd_data;

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      wr_cnt <= '0;
    end else if (inp_valid) begin
      wr_cnt <= wr_cnt + 7'd1;
    end
  end

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      half_1d <= 1'b0;
    end else begin
      half_1d <= wr_cnt[6];
    end
  end

  assign half_done = wr_cnt[6] ^ half_1d;  // Rising or falling edge
  assign rd_last   = (rd_cnt[5:0] == 6'd63);

  // Burst of 64 reads
  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      rd_active <= 1'b0;
    end else if (half_done) begin
      rd_active <= 1'b1;
    end else if (rd_last) begin
      rd_active <= 1'b0;
    end
  end

  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      rd_cnt <= '0;
    end else if (rd_active) begin
      rd_cnt <= rd_cnt + 7'd1;  // Ends on the next half
    end
  end

  // Swap row and column fields
  assign rd_addr = {rd_cnt[6], rd_cnt[2:0], rd_cnt[5:3]};

  dpsram_128x16 u_ram (
    .sclk    (sclk),
    .wr_en   (inp_valid),
    .wr_addr (wr_cnt),
    .wr_data (inp_data),
    .rd_en   (rd_active),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Aligned with the registered RAM output
  always_ff @(posedge sclk or negedge rstn) begin
    if (!rstn) begin
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= rd_active;
    end
  end

  assign mem_data = rd_data;

  // Writes reach the half under read at most on its final read cycle
  a_no_half_overrun: assert property (
    @(posedge sclk) disable iff (!rstn)
    (rd_active && inp_valid && (wr_cnt[6] == rd_cnt[6])) |-> rd_last
  );

endmodule

//--- design/fht_2d_8x8.sv
`timescale 1ns/1ps
`include "fht_defines.svh"

module fht_2d_8x8
  import fht_pkg::*;
(
  input  logic    sclk,
  input  logic    rstn,
  input  logic    in_valid,
  input  sample_t in_data,   // Row-major, 64 per frame
  output logic    out_valid,
  output word_t   out_data   // Column frequency outer, row frequency inner
);

  logic  row_valid;
  word_t row_data;   // Row spectra, row-major
  logic  mem_valid;
  word_t mem_data;   // Same words, column-major

  // Row pass
  fht_1d_8pt #(
    .IN_W (`SAMPLE_W)
  ) u_row (
    .sclk      (sclk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (row_valid),
    .out_data  (row_data)
  );

  // Transpose
  mtx_trps_8x8_dpsram u_trps (
    .sclk      (sclk),
    .rstn      (rstn),
    .inp_valid (row_valid),
    .inp_data  (row_data),
    .mem_valid (mem_valid),
    .mem_data  (mem_data)
  );

  // Column pass on full words
  fht_1d_8pt #(
    .IN_W (`WORD_W)
  ) u_col (
    .sclk      (sclk),
    .rstn      (rstn),
    .in_valid  (mem_valid),
    .in_data   (mem_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

//--- testbench/tb_fht_2d.sv
`timescale 1ns/1ps
`include "fht_defines.svh"

module tb_fht_2d
  import fht_pkg::*;
();

  localparam int N_FRAMES    = 19;                   // 1 + 1 + 8 + 6 + 3 (one partial)
  localparam int CYCLE_LIMIT = 80 * N_FRAMES + 400;
  localparam int DRAIN_LIMIT = 200;                  // Frame latency is under 90 cycles
  localparam int FRAME_WORDS = `FHT_PTS * `FHT_PTS;

  logic    sclk;
  logic    rstn;
  logic    in_valid;
  sample_t in_data;
  logic    out_valid;
  word_t   out_data;

  sample_t     frame_buf [FRAME_WORDS];  // Row-major input frame
  word_t       exp_q [$];                // Expected outputs, k outer, m inner
  logic [31:0] rng_state;
  int          n_errors;
  int          n_checks;
  int          n_tests;
  int          cycle_cnt;
  int          err_start;

  fht_2d_8x8 i_dut (
    .sclk      (sclk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  always #50 sclk = ~sclk;  // 100 ns period

  // Watchdog over the whole run
  always @(posedge sclk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout, the run took more than %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  // 32-bit xorshift
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Shift by the coefficient fraction, keep 16 bits
  function automatic word_t trunc_word(input longint acc);
    longint sh;
    sh = acc >>> `COEF_FRAC;
    return word_t'(sh[`WORD_W-1:0]);
  endfunction

  // Row pass then column pass straight from the cas matrix
  task automatic push_expected();
    longint acc;
    word_t  row_out [FRAME_WORDS];  // row_out[r*8+k]
    for (int r = 0; r < `FHT_PTS; r++) begin
      for (int k = 0; k < `FHT_PTS; k++) begin
        acc = 0;
        for (int n = 0; n < `FHT_PTS; n++) begin
          acc += longint'(frame_buf[r*`FHT_PTS+n]) * longint'(cas_coef(3'(n * k)));
        end
        row_out[r*`FHT_PTS+k] = trunc_word(acc);
      end
    end
    for (int k = 0; k < `FHT_PTS; k++) begin    // Column frequency outer
      for (int m = 0; m < `FHT_PTS; m++) begin  // Row frequency inner
        acc = 0;
        for (int r = 0; r < `FHT_PTS; r++) begin
          acc += longint'(row_out[r*`FHT_PTS+k]) * longint'(cas_coef(3'(r * m)));
        end
        exp_q.push_back(trunc_word(acc));
      end
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < FRAME_WORDS; i++) begin
      frame_buf[i] = sample_t'(next_rand() >> 8);
    end
  endtask

  // Rows of 8 contiguous samples, optional idle gap after each row
  task automatic drive_rows(input int n_rows, input int max_gap);
    int gap;
    for (int r = 0; r < n_rows; r++) begin
      for (int n = 0; n < `FHT_PTS; n++) begin
        @(posedge sclk);
        in_valid <= 1'b1;
        in_data  <= frame_buf[r*`FHT_PTS+n];
      end
      gap = (max_gap > 0) ? int'(next_rand() % (max_gap + 1)) : 0;
      repeat (gap) begin
        @(posedge sclk);
        in_valid <= 1'b0;
        in_data  <= '0;
      end
    end
  endtask

  task automatic drive_idle();
    @(posedge sclk);
    in_valid <= 1'b0;
    in_data  <= '0;
  endtask

  // Wait for every expected word, bounded
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge sclk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      n_errors++;
      $display("%0d expected output words never came out", exp_q.size());
      exp_q.delete();
    end
    repeat (4) @(posedge sclk);  // Room for stray words to show up
  endtask

  task automatic run_random_frames(input int n_frames, input int max_gap);
    for (int f = 0; f < n_frames; f++) begin
      fill_random();
      push_expected();
      drive_rows(`FHT_PTS, max_gap);
    end
    drive_idle();
    wait_drain();
  endtask

  task automatic report_test(input string name);
    n_tests++;
    $display("test %0d %s: %0d errors", n_tests, name, n_errors - err_start);
    err_start = n_errors;
  endtask

  // Output monitor, half a period after the DUT edge
  always @(negedge sclk) begin
    if (rstn && out_valid) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Output word 0x%04h arrived with nothing expected at %0t",
                 out_data, $time);
      end else begin
        check_value("out_data", {16'd0, out_data}, {16'd0, exp_q.pop_front()});
      end
    end
  end

  initial begin
    sclk      = 1'b0;
    rstn      = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    rng_state = 32'hdcff;
    n_errors  = 0;
    n_checks  = 0;
    n_tests   = 0;
    cycle_cnt = 0;
    err_start = 0;

    repeat (2) @(posedge sclk);
    rstn <= 1'b1;

    // Impulse at (0,0), flat spectrum of ones
    for (int i = 0; i < FRAME_WORDS; i++) begin
      frame_buf[i] = '0;
    end
    frame_buf[0] = 8'sd1;
    repeat (FRAME_WORDS) exp_q.push_back(word_t'(1));
    drive_rows(`FHT_PTS, 0);
    drive_idle();
    wait_drain();
    report_test("impulse frame");

    // All ones, only DC survives, 8 per row pass times 8 per column pass
    for (int i = 0; i < FRAME_WORDS; i++) begin
      frame_buf[i] = 8'sd1;
    end
    exp_q.push_back(word_t'(64));
    repeat (FRAME_WORDS - 1) exp_q.push_back(word_t'(0));
    drive_rows(`FHT_PTS, 0);
    drive_idle();
    wait_drain();
    report_test("constant frame");

    run_random_frames(8, 0);
    report_test("back-to-back random frames");

    run_random_frames(6, 2);  // 0 to 2 idle cycles after each row
    report_test("random frames with gaps");

    // One frame coming out and half the next going in, then reset
    fill_random();
    push_expected();
    drive_rows(`FHT_PTS, 0);
    fill_random();
    drive_rows(4, 0);  // Column stage is mid-burst by now
    @(posedge sclk);
    in_valid <= 1'b0;
    in_data  <= '0;
    rstn     <= 1'b0;
    exp_q.delete();  // Neither frame completes
    repeat (2) @(posedge sclk);
    rstn <= 1'b1;
    @(negedge sclk);
    check_value("out_valid", {31'd0, out_valid}, 32'd0);
    run_random_frames(1, 0);
    report_test("reset recovery");

    if (exp_q.size() != 0) begin
      n_errors++;
      $display("%0d expected words left over at the end", exp_q.size());
    end
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
design/fht_pkg.sv
design/dpsram_128x16.sv
design/fht_1d_8pt.sv
design/mtx_trps_8x8_dpsram.sv
design/fht_2d_8x8.sv
testbench/tb_fht_2d.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the 2D FHT testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_fht_2d

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_fht_2d --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# Log decides the verdict
if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
exit 0
